// ==== rtl/csr_pkg.sv ====
package csr_pkg;

    parameter int XLEN = 32;  // One machine word

    // Only M and U exist, encoded as in mstatus.MPP
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_mode_t;

    typedef enum logic [2:0] {
        CSR_NONE  = 3'd0,
        CSR_W     = 3'd1,  // csrrw
        CSR_S     = 3'd2,  // csrrs
        CSR_C     = 3'd3,  // csrrc
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_t;

    // Machine trap setup
    localparam logic [11:0] CSR_ADDR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_ADDR_MISA     = 12'h301;
    localparam logic [11:0] CSR_ADDR_MIE      = 12'h304;
    localparam logic [11:0] CSR_ADDR_MTVEC    = 12'h305;
    // Machine trap handling
    localparam logic [11:0] CSR_ADDR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_ADDR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_ADDR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_ADDR_MIP      = 12'h344;
    // Counters, machine copy and user read-only shadow
    localparam logic [11:0] CSR_ADDR_MCYCLE   = 12'hb00;
    localparam logic [11:0] CSR_ADDR_MCYCLEH  = 12'hb80;
    localparam logic [11:0] CSR_ADDR_CYCLE    = 12'hc00;
    localparam logic [11:0] CSR_ADDR_CYCLEH   = 12'hc80;

    // Interrupt causes carry bit 31
    localparam logic [XLEN-1:0] CAUSE_MSI        = 32'h8000_0003;
    localparam logic [XLEN-1:0] CAUSE_MTI        = 32'h8000_0007;
    localparam logic [XLEN-1:0] CAUSE_MEI        = 32'h8000_000b;
    localparam logic [XLEN-1:0] CAUSE_ECALL_BASE = 32'd8;  // Plus mode, 8 for U, 11 for M

    // MXL=1, extensions A, I, M and U
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4010_1101;

    // mtvec mode field
    localparam logic [1:0] MTVEC_VECTORED = 2'b01;

    // One CSR stage request
    typedef struct packed {
        logic [XLEN-1:0] pc;       // Goes to mepc on a trap
        csr_cmd_t        cmd;
        logic [11:0]     addr;
        logic [XLEN-1:0] operand;  // rs1 value or zimm
    } csr_req_t;

    // Same layout for raw mip bits and for mip & mie
    typedef struct packed {
        logic meip;
        logic msip;
        logic mtip;
    } irq_pending_t;

    typedef struct packed {
        logic            take;    // Redirect this cycle
        logic            is_ret;  // mret, vector is mepc
        logic            is_irq;
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] vector;
    } trap_t;

endpackage

// ==== rtl/csr_access.sv ====
`timescale 1ns/1ps

module csr_access import csr_pkg::*; (
    input  csr_req_t         req,
    input  priv_mode_t       mode,
    input  logic [XLEN-1:0]  raw_rdata,
    output logic [XLEN-1:0]  rdata,
    output logic             wr_en,
    output logic [XLEN-1:0]  wdata
);

    logic can_access;
    logic can_write;
    logic is_rmw;

    // Bits 9:8 give the lowest privilege that may touch the CSR
    assign can_access = req.addr[9:8] <= 2'(mode);
    assign can_write  = can_access && (req.addr[11:10] != 2'b11);  // 11 is read-only space

    assign is_rmw = (req.cmd == CSR_W) || (req.cmd == CSR_S) || (req.cmd == CSR_C);

    assign rdata = can_access ? raw_rdata : '0;  // Denied reads return zero
    assign wr_en = is_rmw && can_write;

    // New value from the old one and the operand
    always_comb begin
        case (req.cmd)
            CSR_W:   wdata = req.operand;
            CSR_S:   wdata = raw_rdata | req.operand;   // Set bits
            CSR_C:   wdata = raw_rdata & ~req.operand;  // Clear bits
            default: wdata = raw_rdata;                 // Not written anyway
        endcase
    end

endmodule

// ==== rtl/csr_regs.sv ====
`timescale 1ns/1ps

module csr_regs import csr_pkg::*; #(
    parameter logic [XLEN-1:0] MTVEC_RESET = '0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid,
    input  csr_req_t         req,
    input  logic             wr_en,
    input  logic [XLEN-1:0]  wdata,
    input  trap_t            trap,
    input  logic [63:0]      cycle,
    input  logic [63:0]      mtime,
    input  logic [63:0]      mtimecmp,
    input  logic             irq_ext,
    output logic [XLEN-1:0]  raw_rdata,
    output priv_mode_t       mode,
    output logic             mstatus_mie,
    output logic [XLEN-1:0]  mtvec,
    output logic [XLEN-1:0]  mepc,
    output irq_pending_t     irq_active
);

    logic             mstatus_mpie;
    priv_mode_t       mstatus_mpp;
    logic             mie_meie;
    logic             mie_msie;
    logic             mie_mtie;
    irq_pending_t     mip;
    logic [XLEN-1:0]  mscratch;
    logic [XLEN-1:0]  mcause;
    logic [XLEN-1:0]  mstatus_word;
    logic [XLEN-1:0]  mie_word;
    logic [XLEN-1:0]  mip_word;
    logic             trap_enter;
    logic             trap_return;
    logic             csr_write;

    assign trap_enter  = trap.take && !trap.is_ret;
    assign trap_return = trap.take && trap.is_ret;
    // An interrupt on a CSR instruction kills its write
    assign csr_write   = valid && wr_en && !trap.take;

    // Only MPP, MPIE and MIE are implemented
    assign mstatus_word = {19'b0, mstatus_mpp, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
    assign mie_word     = {20'b0, mie_meie, 3'b0, mie_mtie, 3'b0, mie_msie, 3'b0};
    assign mip_word     = {20'b0, mip.meip, 3'b0, mip.mtip, 3'b0, mip.msip, 3'b0};

    // Pending and enabled, for the trap logic
    assign irq_active.meip = mip.meip & mie_meie;
    assign irq_active.msip = mip.msip & mie_msie;
    assign irq_active.mtip = mip.mtip & mie_mtie;

    always_ff @(posedge clk) begin
        if (rst) begin
            mode         <= PRIV_M;  // Boot in machine mode
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= PRIV_U;
            mie_meie     <= 1'b0;
            mie_msie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mip          <= '0;
            mtvec        <= MTVEC_RESET;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else begin
            // Timer and external lines are resampled every edge
            mip.mtip <= mtime >= mtimecmp;
            mip.meip <= irq_ext;

            if (trap_enter) begin
                mepc         <= req.pc;
                mcause       <= trap.cause;
                mstatus_mpie <= mstatus_mie;  // Push the enable stack
                mstatus_mie  <= 1'b0;
                mstatus_mpp  <= mode;
                mode         <= PRIV_M;
                if (trap.is_irq && trap.cause == CAUSE_MSI) begin
                    mip.msip <= 1'b0;  // Software interrupt is acknowledged by taking it
                end
            end else if (trap_return) begin
                mstatus_mie  <= mstatus_mpie;  // Pop the enable stack
                mode         <= mstatus_mpp;
                mstatus_mpie <= 1'b1;
                mstatus_mpp  <= PRIV_U;        // Least privileged mode
            end else if (csr_write) begin
                case (req.addr)
                    CSR_ADDR_MSTATUS: begin
                        // MPP is WARL, anything but 11 lands on U
                        mstatus_mpp  <= (wdata[12:11] == 2'b11) ? PRIV_M : PRIV_U;
                        mstatus_mpie <= wdata[7];
                        mstatus_mie  <= wdata[3];
                    end
                    CSR_ADDR_MIE: begin
                        mie_meie <= wdata[11];
                        mie_mtie <= wdata[7];
                        mie_msie <= wdata[3];
                    end
                    CSR_ADDR_MTVEC:    mtvec    <= wdata;
                    CSR_ADDR_MSCRATCH: mscratch <= wdata;
                    CSR_ADDR_MEPC:     mepc     <= {wdata[XLEN-1:2], 2'b00};  // Word aligned
                    CSR_ADDR_MCAUSE:   mcause   <= wdata;
                    CSR_ADDR_MIP:      mip.msip <= wdata[3];  // MEIP and MTIP follow hardware
                    default: ;  // Counters and misa ignore writes
                endcase
            end
        end
    end

    // Read mux, unlisted addresses read zero
    always_comb begin
        case (req.addr)
            CSR_ADDR_MSTATUS:  raw_rdata = mstatus_word;
            CSR_ADDR_MISA:     raw_rdata = MISA_VALUE;
            CSR_ADDR_MIE:      raw_rdata = mie_word;
            CSR_ADDR_MTVEC:    raw_rdata = mtvec;
            CSR_ADDR_MSCRATCH: raw_rdata = mscratch;
            CSR_ADDR_MEPC:     raw_rdata = mepc;
            CSR_ADDR_MCAUSE:   raw_rdata = mcause;
            CSR_ADDR_MIP:      raw_rdata = mip_word;
            CSR_ADDR_MCYCLE:   raw_rdata = cycle[31:0];
            CSR_ADDR_MCYCLEH:  raw_rdata = cycle[63:32];
            CSR_ADDR_CYCLE:    raw_rdata = cycle[31:0];   // User view
            CSR_ADDR_CYCLEH:   raw_rdata = cycle[63:32];
            default:           raw_rdata = '0;
        endcase
    end

endmodule

// ==== rtl/trap_ctrl.sv ====
`timescale 1ns/1ps

module trap_ctrl import csr_pkg::*; (
    input  logic             valid,
    input  csr_req_t         req,
    input  priv_mode_t       mode,
    input  logic             mstatus_mie,
    input  logic [XLEN-1:0]  mtvec,
    input  logic [XLEN-1:0]  mepc,
    input  irq_pending_t     irq_active,
    output trap_t            trap
);

    logic             is_ecall;
    logic             is_mret;
    logic             irq_eligible;
    logic             irq_take;
    logic             ret_take;
    logic [XLEN-1:0]  irq_cause;
    logic [XLEN-1:0]  ecall_cause;
    logic [XLEN-1:0]  base;

    assign is_ecall = req.cmd == CSR_ECALL;
    assign is_mret  = req.cmd == CSR_MRET;

    // U-mode always takes M interrupts, M-mode only with MIE
    assign irq_eligible = (mode == PRIV_U) || mstatus_mie;

    // Exception wins over interrupts, interrupts win over mret
    assign irq_take = irq_eligible && (irq_active != '0) && !is_ecall;
    assign ret_take = is_mret && !irq_take;

    // Fixed order MEI, MSI, MTI
    always_comb begin
        if (irq_active.meip) begin
            irq_cause = CAUSE_MEI;
        end else if (irq_active.msip) begin
            irq_cause = CAUSE_MSI;
        end else if (irq_active.mtip) begin
            irq_cause = CAUSE_MTI;
        end else begin
            irq_cause = '0;
        end
    end

    assign ecall_cause = CAUSE_ECALL_BASE + XLEN'(mode);  // 8 from U, 11 from M
    assign base        = {mtvec[XLEN-1:2], 2'b00};

    always_comb begin
        trap.take   = valid && (is_ecall || irq_take || is_mret);
        trap.is_ret = ret_take;
        trap.is_irq = irq_take;

        if (is_ecall) begin
            trap.cause = ecall_cause;
        end else if (irq_take) begin
            trap.cause = irq_cause;
        end else begin
            trap.cause = '0;  // mret has no cause
        end

        if (ret_take) begin
            trap.vector = mepc;  // Straight back, no extra cycle
        end else if (irq_take && mtvec[1:0] == MTVEC_VECTORED) begin
            trap.vector = base + {irq_cause[XLEN-3:0], 2'b00};  // base + 4 * code
        end else begin
            trap.vector = base;  // Exceptions always use the base
        end
    end

endmodule

// ==== rtl/csr_stage.sv ====
`timescale 1ns/1ps

module csr_stage import csr_pkg::*; #(
    parameter logic [XLEN-1:0] MTVEC_RESET = '0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid,
    input  csr_req_t         req,
    input  logic [63:0]      cycle,
    input  logic [63:0]      mtime,
    input  logic [63:0]      mtimecmp,
    input  logic             irq_ext,
    output logic [XLEN-1:0]  rdata,
    output logic             trap_flg,
    output logic [XLEN-1:0]  trap_vector,
    output priv_mode_t       mode
);

    logic [XLEN-1:0]  raw_rdata;
    logic             wr_en;
    logic [XLEN-1:0]  wdata;
    logic             mstatus_mie;
    logic [XLEN-1:0]  mtvec;
    logic [XLEN-1:0]  mepc;
    irq_pending_t     irq_active;
    trap_t            trap;

    // Permission check and write data
    csr_access u_access (
        .req       (req),
        .mode      (mode),
        .raw_rdata (raw_rdata),
        .rdata     (rdata),
        .wr_en     (wr_en),
        .wdata     (wdata)
    );

    // State and read mux
    csr_regs #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_regs (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .req         (req),
        .wr_en       (wr_en),
        .wdata       (wdata),
        .trap        (trap),
        .cycle       (cycle),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .irq_ext     (irq_ext),
        .raw_rdata   (raw_rdata),
        .mode        (mode),
        .mstatus_mie (mstatus_mie),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .irq_active  (irq_active)
    );

    // Trap decision and redirect target
    trap_ctrl u_trap (
        .valid       (valid),
        .req         (req),
        .mode        (mode),
        .mstatus_mie (mstatus_mie),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .irq_active  (irq_active),
        .trap        (trap)
    );

    assign trap_flg    = trap.take;
    assign trap_vector = trap.vector;

endmodule

// ==== tests/csr_stage_tb.sv ====
`timescale 1ns/1ps

module csr_stage_tb import csr_pkg::*; ;

    localparam int               CLK_PERIOD   = 8;
    localparam int               RESET_CYCLES = 10;
    localparam int               TEST_CYCLES  = 90;  // Requests plus idle gaps, rounded up
    localparam int               WD_MARGIN    = 20 * CLK_PERIOD;
    localparam logic [XLEN-1:0]  MTVEC_RESET  = 32'h0000_0100;

    logic             clk;
    logic             rst;
    logic             valid;
    csr_req_t         req;
    logic [63:0]      cycle = 64'h0000_0002_ffff_fff0;  // Close to a carry into the high half
    logic [63:0]      mtime;
    logic [63:0]      mtimecmp;
    logic             irq_ext;
    logic [XLEN-1:0]  rdata;
    logic             trap_flg;
    logic [XLEN-1:0]  trap_vector;
    priv_mode_t       mode;

    int               error_count = 0;
    logic [31:0]      lfsr_state  = 32'd57;
    logic [XLEN-1:0]  pc_next     = 32'h0000_1000;

    // Reference model state
    priv_mode_t       m_mode;
    logic             m_glob_ie;    // mstatus.MIE
    logic             m_prev_ie;    // mstatus.MPIE
    priv_mode_t       m_prev_mode;  // mstatus.MPP
    logic [XLEN-1:0]  m_ie_mask;    // mie, bits 11, 7 and 3 only
    logic             m_msip;
    logic             m_mtip;
    logic             m_meip;
    logic [XLEN-1:0]  m_mtvec;
    logic [XLEN-1:0]  m_mscratch;
    logic [XLEN-1:0]  m_mepc;
    logic [XLEN-1:0]  m_mcause;

    // Model outputs for the request on the bus
    logic [XLEN-1:0]  model_value;
    logic [XLEN-1:0]  new_value;
    logic [XLEN-1:0]  mtvec_base;
    logic [XLEN-1:0]  irq_cause;
    logic             permitted;
    logic             irq_now;
    logic             exp_wr;
    logic             exp_ret;
    logic             exp_trap;
    logic [XLEN-1:0]  exp_rdata;
    logic [XLEN-1:0]  exp_cause;
    logic [XLEN-1:0]  exp_vector;

    csr_stage #(
        .MTVEC_RESET (MTVEC_RESET)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .req         (req),
        .cycle       (cycle),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .irq_ext     (irq_ext),
        .rdata       (rdata),
        .trap_flg    (trap_flg),
        .trap_vector (trap_vector),
        .mode        (mode)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 64'd1;  // Free running counter

    // x^32 + x^22 + x^2 + x + 1, shifting right
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] lfsr_bits(input int nbits);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    always_comb begin
        case (req.addr)
            CSR_ADDR_MSTATUS:  model_value = (32'(m_prev_mode) << 11) | (32'(m_prev_ie) << 7)
                                             | (32'(m_glob_ie) << 3);
            CSR_ADDR_MISA:     model_value = MISA_VALUE;
            CSR_ADDR_MIE:      model_value = m_ie_mask;
            CSR_ADDR_MTVEC:    model_value = m_mtvec;
            CSR_ADDR_MSCRATCH: model_value = m_mscratch;
            CSR_ADDR_MEPC:     model_value = m_mepc;
            CSR_ADDR_MCAUSE:   model_value = m_mcause;
            CSR_ADDR_MIP:      model_value = (32'(m_meip) << 11) | (32'(m_mtip) << 7)
                                             | (32'(m_msip) << 3);
            CSR_ADDR_MCYCLE, CSR_ADDR_CYCLE:   model_value = cycle[31:0];
            CSR_ADDR_MCYCLEH, CSR_ADDR_CYCLEH: model_value = cycle[63:32];
            default:           model_value = '0;
        endcase
        // Only U and M exist, so U may touch the 00 level alone
        permitted = (m_mode == PRIV_M) || (req.addr[9:8] == 2'b00);
        exp_rdata = permitted ? model_value : '0;
        exp_wr    = permitted && (req.addr[11:10] != 2'b11)
                    && (req.cmd == CSR_W || req.cmd == CSR_S || req.cmd == CSR_C);
        case (req.cmd)
            CSR_S:   new_value = model_value | req.operand;
            CSR_C:   new_value = model_value & ~req.operand;
            default: new_value = req.operand;
        endcase
        irq_now = ((m_mode == PRIV_U) || m_glob_ie) && (req.cmd != CSR_ECALL)
                  && ((m_meip && m_ie_mask[11]) || (m_msip && m_ie_mask[3])
                      || (m_mtip && m_ie_mask[7]));
        if (m_meip && m_ie_mask[11]) irq_cause = CAUSE_MEI;
        else if (m_msip && m_ie_mask[3]) irq_cause = CAUSE_MSI;
        else irq_cause = CAUSE_MTI;
        exp_ret    = (req.cmd == CSR_MRET) && !irq_now;
        exp_trap   = valid && ((req.cmd == CSR_ECALL) || irq_now || (req.cmd == CSR_MRET));
        mtvec_base = m_mtvec & ~32'h3;
        if (req.cmd == CSR_ECALL) begin
            exp_cause  = (m_mode == PRIV_M) ? CAUSE_ECALL_BASE + 32'd3 : CAUSE_ECALL_BASE;
            exp_vector = mtvec_base;
        end else if (irq_now) begin
            exp_cause  = irq_cause;
            exp_vector = mtvec_base;
            if (m_mtvec[1:0] == 2'b01) exp_vector = mtvec_base + ((irq_cause & 32'h7fff_ffff) << 2);
        end else begin
            exp_cause  = '0;
            exp_vector = m_mepc;  // mret target
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            m_mode      <= PRIV_M;
            m_glob_ie   <= 1'b0;
            m_prev_ie   <= 1'b0;
            m_prev_mode <= PRIV_U;
            m_ie_mask   <= '0;
            m_msip      <= 1'b0;
            m_mtip      <= 1'b0;
            m_meip      <= 1'b0;
            m_mtvec     <= MTVEC_RESET;
            m_mscratch  <= '0;
            m_mepc      <= '0;
            m_mcause    <= '0;
        end else begin
            m_mtip <= mtime >= mtimecmp;
            m_meip <= irq_ext;
            if (exp_trap && !exp_ret) begin
                m_mepc      <= req.pc;
                m_mcause    <= exp_cause;
                m_prev_ie   <= m_glob_ie;
                m_glob_ie   <= 1'b0;
                m_prev_mode <= m_mode;
                m_mode      <= PRIV_M;
                if (exp_cause == CAUSE_MSI) m_msip <= 1'b0;
            end else if (exp_trap) begin
                m_glob_ie   <= m_prev_ie;
                m_mode      <= m_prev_mode;
                m_prev_ie   <= 1'b1;
                m_prev_mode <= PRIV_U;
            end else if (valid && exp_wr) begin
                case (req.addr)
                    CSR_ADDR_MSTATUS: begin
                        m_prev_mode <= (new_value[12:11] == 2'b11) ? PRIV_M : PRIV_U;
                        m_prev_ie   <= new_value[7];
                        m_glob_ie   <= new_value[3];
                    end
                    CSR_ADDR_MIE:      m_ie_mask  <= new_value & 32'h0000_0888;
                    CSR_ADDR_MTVEC:    m_mtvec    <= new_value;
                    CSR_ADDR_MSCRATCH: m_mscratch <= new_value;
                    CSR_ADDR_MEPC:     m_mepc     <= new_value & ~32'h3;
                    CSR_ADDR_MCAUSE:   m_mcause   <= new_value;
                    CSR_ADDR_MIP:      m_msip     <= new_value[3];
                    default: ;
                endcase
            end
        end
    end

    rdata_check: assert property (@(posedge clk) disable iff (rst) !valid || rdata == exp_rdata)
        else begin
            $display("Fail at %0t: rdata is %h, expected %h", $time, $sampled(rdata),
                     $sampled(exp_rdata));
            error_count = error_count + 1;
        end
    trap_check: assert property (@(posedge clk) disable iff (rst) trap_flg == exp_trap)
        else begin
            $display("Fail at %0t: trap_flg is %b, expected %b", $time, $sampled(trap_flg),
                     $sampled(exp_trap));
            error_count = error_count + 1;
        end
    vector_check: assert property (@(posedge clk) disable iff (rst)
                                   !exp_trap || trap_vector == exp_vector)
        else begin
            $display("Fail at %0t: trap_vector is %h, expected %h", $time,
                     $sampled(trap_vector), $sampled(exp_vector));
            error_count = error_count + 1;
        end
    mode_check: assert property (@(posedge clk) disable iff (rst) mode == m_mode)
        else begin
            $display("Fail at %0t: mode is %0d, expected %0d", $time, $sampled(mode),
                     $sampled(m_mode));
            error_count = error_count + 1;
        end

    // One request for one cycle, starting on a rising edge
    task automatic issue_request(input csr_cmd_t cmd, input logic [11:0] addr,
                                 input logic [XLEN-1:0] operand);
        valid       <= 1'b1;
        req.pc      <= pc_next;
        req.cmd     <= cmd;
        req.addr    <= addr;
        req.operand <= operand;
        pc_next = pc_next + 32'd4;
        @(posedge clk);
        valid <= 1'b0;
    endtask

    task automatic csr_read(input logic [11:0] addr);
        issue_request(CSR_S, addr, '0);  // Set with zero leaves the value alone
    endtask

    task automatic wait_cycles(input int n);
        valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    initial begin
        rst      = 1'b1;
        valid    = 1'b0;
        req      = '0;
        mtime    = 64'd0;
        mtimecmp = '1;  // Timer far away
        irq_ext  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        wait_cycles(2);
        csr_read(CSR_ADDR_MSTATUS);
        csr_read(CSR_ADDR_MTVEC);
        csr_read(CSR_ADDR_MISA);
        wait_cycles(2);
        issue_request(CSR_W, CSR_ADDR_MSCRATCH, lfsr_bits(32));
        issue_request(CSR_S, CSR_ADDR_MSCRATCH, lfsr_bits(32));
        issue_request(CSR_C, CSR_ADDR_MSCRATCH, lfsr_bits(32));
        csr_read(CSR_ADDR_MSCRATCH);
        issue_request(CSR_ECALL, 12'h000, '0);  // From M, cause 11
        csr_read(CSR_ADDR_MCAUSE);
        csr_read(CSR_ADDR_MEPC);
        csr_read(CSR_ADDR_MSTATUS);
        // Back to U through mret with MPP cleared
        issue_request(CSR_W, CSR_ADDR_MSTATUS, '0);
        issue_request(CSR_W, CSR_ADDR_MEPC, lfsr_bits(32));  // Low bits dropped
        issue_request(CSR_MRET, 12'h000, '0);
        csr_read(CSR_ADDR_MSCRATCH);
        issue_request(CSR_W, CSR_ADDR_MSCRATCH, lfsr_bits(32));
        csr_read(CSR_ADDR_CYCLE);
        csr_read(CSR_ADDR_CYCLEH);
        issue_request(CSR_W, CSR_ADDR_CYCLE, lfsr_bits(32));
        issue_request(CSR_ECALL, 12'h000, '0);
        csr_read(CSR_ADDR_MCAUSE);
        csr_read(CSR_ADDR_MSCRATCH);
        // Timer through vectored mtvec
        issue_request(CSR_W, CSR_ADDR_MTVEC, 32'h0000_0201);
        issue_request(CSR_W, CSR_ADDR_MIE, 32'h0000_0080);
        issue_request(CSR_S, CSR_ADDR_MSTATUS, 32'h0000_0008);
        mtime    <= 64'd100;
        mtimecmp <= 64'd50;
        wait_cycles(2);
        csr_read(CSR_ADDR_MCAUSE);  // Taken here
        csr_read(CSR_ADDR_MCAUSE);
        mtimecmp <= '1;
        wait_cycles(2);
        // External and software pending together
        issue_request(CSR_W, CSR_ADDR_MIE, 32'h0000_0888);
        issue_request(CSR_S, CSR_ADDR_MIP, 32'h0000_0008);
        irq_ext <= 1'b1;
        wait_cycles(2);
        issue_request(CSR_S, CSR_ADDR_MSTATUS, 32'h0000_0008);
        csr_read(CSR_ADDR_MIP);     // External first
        csr_read(CSR_ADDR_MCAUSE);
        irq_ext <= 1'b0;
        wait_cycles(2);
        issue_request(CSR_MRET, 12'h000, '0);
        csr_read(CSR_ADDR_MIP);     // Software next
        csr_read(CSR_ADDR_MIP);
        csr_read(CSR_ADDR_MCAUSE);
        wait_cycles(2);
        $display("Checks done, error count %0d", error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #((RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD + WD_MARGIN);
        $display("Timeout, the test sequence did not finish in time");
        $display("Errors found");
        $finish;
    end

endmodule

// ==== csr_stage.f ====
rtl/csr_pkg.sv
rtl/csr_access.sv
rtl/csr_regs.sv
rtl/trap_ctrl.sv
rtl/csr_stage.sv
tests/csr_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CSR stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
FAIL_TEXT="Errors found"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module csr_stage_tb -Mdir "$BUILD_DIR" -o csr_stage_sim -f csr_stage.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BUILD_DIR/csr_stage_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "$FAIL_TEXT" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
exit 0
